//--- Makefile
VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/exec_alu.sv
`timescale 1ns/1ns

module exec_alu import rv_isa_pkg::*, exec_pkg::*; (
   input  ctrl_t           i_ctrl,
   input  logic [XLEN-1:0] i_rs1,
   input  logic [XLEN-1:0] i_rs2,
   input  logic [XLEN-1:0] i_imm,
   output logic [XLEN-1:0] o_result,
   output logic            o_cmp_lt,
   output logic            o_cmp_ltu,
   output logic            o_cmp_eq
);

   logic [XLEN-1:0]    op_b;
   logic [SHAMT_W-1:0] shamt;

   assign op_b  = i_ctrl.use_imm ? i_imm : i_rs2;
   assign shamt = op_b[SHAMT_W-1:0];

   // branches see rs2 here since they never take the immediate
   assign o_cmp_eq  = (i_rs1 == op_b);
   assign o_cmp_lt  = ($signed(i_rs1) < $signed(op_b));
   assign o_cmp_ltu = (i_rs1 < op_b);

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_ADD:  o_result = i_rs1 + op_b;
         ALU_SUB:  o_result = i_rs1 - op_b;
         ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, o_cmp_lt};
         ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_cmp_ltu};
         ALU_XOR:  o_result = i_rs1 ^ op_b;
         ALU_OR:   o_result = i_rs1 | op_b;
         ALU_AND:  o_result = i_rs1 & op_b;
         ALU_SLL:  o_result = i_rs1 << shamt;
         ALU_SRL:  o_result = i_rs1 >> shamt;
         ALU_SRA:  o_result = $unsigned($signed(i_rs1) >>> shamt);
         default:  o_result = '0;
      endcase
   end

endmodule

//--- logic/exec_commit.sv
`timescale 1ns/1ns

module exec_commit import rv_isa_pkg::*, exec_pkg::*; (
   input  ctrl_t           i_ctrl,
   input  logic [XLEN-1:0] i_pc,
   input  logic [XLEN-1:0] i_imm,
   input  logic [XLEN-1:0] i_rs1,
   input  logic [XLEN-1:0] i_alu_result,
   input  logic            i_cmp_eq,
   input  logic            i_cmp_lt,
   input  logic            i_cmp_ltu,
   input  logic [XLEN-1:0] i_load_data,
   input  logic            i_mem_done,
   reg_port_if.core        regs,
   output logic            o_pc_change,
   output logic [XLEN-1:0] o_new_pc,
   output logic            o_finished
);

   logic            taken;
   logic [XLEN-1:0] pc_imm;
   logic [XLEN-1:0] jalr_target;
   logic [XLEN-1:0] wb_data;

   always_comb begin
      case (i_ctrl.branch_f3)
         F3_BEQ:  taken = i_cmp_eq;
         F3_BNE:  taken = !i_cmp_eq;
         F3_BLT:  taken = i_cmp_lt;
         F3_BGE:  taken = !i_cmp_lt;
         F3_BLTU: taken = i_cmp_ltu;
         F3_BGEU: taken = !i_cmp_ltu;
         default: taken = 1'b0;
      endcase
   end

   assign pc_imm = i_pc + i_imm;

   // jalr target has bit 0 forced low
   assign jalr_target = (i_rs1 + i_imm) & ~XLEN'(1);

   assign o_pc_change = i_ctrl.is_jal || i_ctrl.is_jalr || (i_ctrl.is_branch && taken);
   assign o_new_pc    = i_ctrl.is_jalr ? jalr_target : pc_imm;

   // only memory ops can stall
   assign o_finished = (i_ctrl.mem_kind == MEM_NONE) ? 1'b1 : i_mem_done;

   always_comb begin
      case (i_ctrl.wb_src)
         WB_ALU:    wb_data = i_alu_result;
         WB_IMM:    wb_data = i_imm;
         WB_PC_IMM: wb_data = pc_imm;
         WB_LINK:   wb_data = i_pc + XLEN'(INST_BYTES);
         WB_LOAD:   wb_data = i_load_data;
         default:   wb_data = i_alu_result;
      endcase
   end

   assign regs.rd_we   = i_ctrl.reg_we && o_finished;
   assign regs.rd_data = wb_data;

endmodule

//--- logic/exec_decoder.sv
`timescale 1ns/1ns

module exec_decoder import rv_isa_pkg::*, exec_pkg::*; (
   input  inst_t           i_inst,
   output ctrl_t           o_ctrl,
   output logic [XLEN-1:0] o_imm,
   output logic            o_invalid,
   reg_port_if.core        regs
);

   logic [OPC_W-1:0] opcode;
   logic [2:0]       f3;
   logic [6:0]       f7;
   logic             alt;
   logic             f7_zero;
   logic [XLEN-1:0]  imm_i;
   logic [XLEN-1:0]  imm_s;
   logic [XLEN-1:0]  imm_b;
   logic [XLEN-1:0]  imm_u;
   logic [XLEN-1:0]  imm_j;
   logic [XLEN-1:0]  imm;
   alu_op_e          base_op;
   ctrl_t            ctrl;
   logic             bad;

   assign opcode  = i_inst[OPC_W-1:0];
   assign f3      = i_inst[F3_LSB +: 3];
   assign f7      = i_inst[F7_LSB +: 7];
   assign alt     = (f7 == F7_ALT);
   assign f7_zero = (f7 == '0);

   assign regs.rs1_addr = i_inst[RS1_LSB +: REG_ADDR_W];
   assign regs.rs2_addr = i_inst[RS2_LSB +: REG_ADDR_W];
   assign regs.rd_addr  = i_inst[RD_LSB +: REG_ADDR_W];

   // sign-extended immediates per format
   assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
   assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
   assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                   i_inst[11:8], 1'b0};
   assign imm_u = {i_inst[31:12], 12'b0};
   assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                   i_inst[30:21], 1'b0};

   // SUB only exists in register form
   always_comb begin
      case (f3)
         F3_ADD:  base_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
         F3_SLL:  base_op = ALU_SLL;
         F3_SLT:  base_op = ALU_SLT;
         F3_SLTU: base_op = ALU_SLTU;
         F3_XOR:  base_op = ALU_XOR;
         F3_SR:   base_op = alt ? ALU_SRA : ALU_SRL;
         F3_OR:   base_op = ALU_OR;
         default: base_op = ALU_AND;
      endcase
   end

   always_comb begin
      ctrl = '0;
      imm  = '0;
      bad  = 1'b0;
      case (opcode)
         OPC_LUI: begin
            ctrl.reg_we = 1'b1;
            ctrl.wb_src = WB_IMM;
            imm         = imm_u;
         end
         OPC_AUIPC: begin
            ctrl.reg_we = 1'b1;
            ctrl.wb_src = WB_PC_IMM;
            imm         = imm_u;
         end
         OPC_JAL: begin
            ctrl.reg_we = 1'b1;
            ctrl.wb_src = WB_LINK;
            ctrl.is_jal = 1'b1;
            imm         = imm_j;
         end
         OPC_JALR: begin
            ctrl.reg_we  = 1'b1;
            ctrl.wb_src  = WB_LINK;
            ctrl.is_jalr = 1'b1;
            imm          = imm_i;
            bad          = (f3 != F3_JALR);
         end
         OPC_BRANCH: begin
            ctrl.is_branch = 1'b1;
            ctrl.branch_f3 = f3;
            imm            = imm_b;
            bad = !(f3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
         end
         OPC_LOAD: begin
            ctrl.reg_we   = 1'b1;
            ctrl.use_imm  = 1'b1;
            ctrl.wb_src   = WB_LOAD;
            ctrl.mem_kind = MEM_LOAD;
            ctrl.load_f3  = f3;
            imm           = imm_i;
            bad = !(f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
         end
         OPC_STORE: begin
            // word stores only
            ctrl.use_imm  = 1'b1;
            ctrl.mem_kind = MEM_STORE;
            imm           = imm_s;
            bad           = (f3 != F3_SW);
         end
         OPC_OP_IMM: begin
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.alu_op  = base_op;
            imm          = imm_i;
            if (f3 == F3_SLL) begin
               bad = !f7_zero;
            end else if (f3 == F3_SR) begin
               bad = !(f7_zero || alt);
            end
         end
         OPC_OP: begin
            ctrl.reg_we = 1'b1;
            ctrl.alu_op = base_op;
            bad = !(f7_zero || (alt && (f3 == F3_ADD || f3 == F3_SR)));
         end
         default: begin
            bad = 1'b1;
         end
      endcase
      if (bad) begin
         ctrl = '0;
      end
   end

   assign o_ctrl    = ctrl;
   assign o_imm     = imm;
   assign o_invalid = bad;

endmodule

//--- logic/exec_lsu.sv
`timescale 1ns/1ns

module exec_lsu import rv_isa_pkg::*, exec_pkg::*; (
   input  logic            clk,
   input  logic            i_arst_n,
   input  ctrl_t           i_ctrl,
   input  logic [XLEN-1:0] i_addr,
   input  logic [XLEN-1:0] i_store_data,
   output logic [XLEN-1:0] o_addr,
   output logic            o_rd_ready,
   input  logic            i_rd_valid,
   input  logic [XLEN-1:0] i_rd_data,
   output logic            o_wr_valid,
   output logic [XLEN-1:0] o_wr_data,
   output logic [2:0]      o_wr_width,
   input  logic            i_wr_ready,
   output logic [XLEN-1:0] o_load_data,
   output logic            o_mem_done
);

   logic            is_load;
   logic            is_store;
   logic            buf_valid_q;
   logic [XLEN-1:0] buf_q;
   logic [XLEN-1:0] lane;

   assign is_load  = (i_ctrl.mem_kind == MEM_LOAD);
   assign is_store = (i_ctrl.mem_kind == MEM_STORE);

   assign o_addr     = i_addr;
   assign o_rd_ready = is_load && !buf_valid_q;
   assign o_wr_valid = is_store;
   assign o_wr_data  = i_store_data;
   assign o_wr_width = is_store ? WR_WIDTH_WORD : '0;

   // a full buffer means the load completes at this edge
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         buf_valid_q <= 1'b0;
      end else if (buf_valid_q) begin
         buf_valid_q <= 1'b0;
      end else if (o_rd_ready && i_rd_valid) begin
         buf_valid_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (o_rd_ready && i_rd_valid) begin
         buf_q <= i_rd_data;
      end
   end

   // bring the addressed byte down to lane 0
   assign lane = buf_q >> {i_addr[1:0], 3'b000};

   always_comb begin
      case (i_ctrl.load_f3)
         F3_LB:   o_load_data = {{24{lane[7]}}, lane[7:0]};
         F3_LBU:  o_load_data = {24'b0, lane[7:0]};
         F3_LH:   o_load_data = {{16{lane[15]}}, lane[15:0]};
         F3_LHU:  o_load_data = {16'b0, lane[15:0]};
         F3_LW:   o_load_data = lane;
         default: o_load_data = lane;
      endcase
   end

   assign o_mem_done = is_load ? buf_valid_q : (is_store && i_wr_ready);

endmodule

//--- logic/exec_pkg.sv
package exec_pkg;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_op_e;

   // where the register writeback value comes from
   typedef enum logic [2:0] {
      WB_ALU,
      WB_IMM,
      WB_PC_IMM,
      WB_LINK,
      WB_LOAD
   } wb_src_e;

   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_LOAD,
      MEM_STORE
   } mem_kind_e;

   // all-zero value is a harmless no-op
   typedef struct packed {
      alu_op_e    alu_op;
      logic       use_imm;
      wb_src_e    wb_src;
      logic       reg_we;
      mem_kind_e  mem_kind;
      logic [2:0] load_f3;
      logic       is_branch;
      logic [2:0] branch_f3;
      logic       is_jal;
      logic       is_jalr;
   } ctrl_t;

   // byte count reported for a word store
   localparam logic [2:0] WR_WIDTH_WORD = 3'd4;

endpackage

//--- logic/exec_regfile.sv
`timescale 1ns/1ns

module exec_regfile import rv_isa_pkg::*; (
   input  logic     clk,
   input  logic     i_arst_n,
   reg_port_if.file regs
);

   localparam int NUM_REGS = 1 << REG_ADDR_W;

   // x0 has no storage
   logic [XLEN-1:0] x_q [1:NUM_REGS-1];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            x_q[i] <= '0;
         end
      end else if (regs.rd_we && regs.rd_addr != '0) begin
         x_q[regs.rd_addr] <= regs.rd_data;
      end
   end

   // two asynchronous read ports
   assign regs.rs1_data = (regs.rs1_addr == '0) ? '0 : x_q[regs.rs1_addr];
   assign regs.rs2_data = (regs.rs2_addr == '0) ? '0 : x_q[regs.rs2_addr];

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ns

module exec_unit import rv_isa_pkg::*, exec_pkg::*; (
   input  logic            clk,
   input  logic            i_arst_n,
   input  inst_t           i_inst,
   input  logic [XLEN-1:0] i_pc,
   output logic [XLEN-1:0] o_addr,
   output logic            o_rd_ready,
   input  logic            i_rd_valid,
   input  logic [XLEN-1:0] i_rd_data,
   output logic            o_wr_valid,
   output logic [XLEN-1:0] o_wr_data,
   output logic [2:0]      o_wr_width,
   input  logic            i_wr_ready,
   output logic            o_pc_change,
   output logic [XLEN-1:0] o_new_pc,
   output logic            o_finished,
   output logic            o_invalid_inst
);

   reg_port_if regs ();

   ctrl_t           ctrl;
   logic [XLEN-1:0] imm;
   logic [XLEN-1:0] alu_result;
   logic [XLEN-1:0] load_data;
   logic            cmp_eq;
   logic            cmp_lt;
   logic            cmp_ltu;
   logic            mem_done;

   exec_decoder u_decoder (
      .i_inst    (i_inst),
      .o_ctrl    (ctrl),
      .o_imm     (imm),
      .o_invalid (o_invalid_inst),
      .regs      (regs.core)
   );

   exec_regfile u_regfile (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .regs     (regs.file)
   );

   exec_alu u_alu (
      .i_ctrl    (ctrl),
      .i_rs1     (regs.rs1_data),
      .i_rs2     (regs.rs2_data),
      .i_imm     (imm),
      .o_result  (alu_result),
      .o_cmp_lt  (cmp_lt),
      .o_cmp_ltu (cmp_ltu),
      .o_cmp_eq  (cmp_eq)
   );

   // load and store address is the alu sum
   exec_lsu u_lsu (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_ctrl       (ctrl),
      .i_addr       (alu_result),
      .i_store_data (regs.rs2_data),
      .o_addr       (o_addr),
      .o_rd_ready   (o_rd_ready),
      .i_rd_valid   (i_rd_valid),
      .i_rd_data    (i_rd_data),
      .o_wr_valid   (o_wr_valid),
      .o_wr_data    (o_wr_data),
      .o_wr_width   (o_wr_width),
      .i_wr_ready   (i_wr_ready),
      .o_load_data  (load_data),
      .o_mem_done   (mem_done)
   );

   exec_commit u_commit (
      .i_ctrl       (ctrl),
      .i_pc         (i_pc),
      .i_imm        (imm),
      .i_rs1        (regs.rs1_data),
      .i_alu_result (alu_result),
      .i_cmp_eq     (cmp_eq),
      .i_cmp_lt     (cmp_lt),
      .i_cmp_ltu    (cmp_ltu),
      .i_load_data  (load_data),
      .i_mem_done   (mem_done),
      .regs         (regs.core),
      .o_pc_change  (o_pc_change),
      .o_new_pc     (o_new_pc),
      .o_finished   (o_finished)
   );

endmodule

//--- logic/reg_port_if.sv
`timescale 1ns/1ns

interface reg_port_if import rv_isa_pkg::*; ();

   logic [REG_ADDR_W-1:0] rs1_addr;
   logic [REG_ADDR_W-1:0] rs2_addr;
   logic [XLEN-1:0]       rs1_data;
   logic [XLEN-1:0]       rs2_data;
   logic                  rd_we;
   logic [REG_ADDR_W-1:0] rd_addr;
   logic [XLEN-1:0]       rd_data;

   modport core (output rs1_addr, rs2_addr, rd_we, rd_addr, rd_data,
                 input  rs1_data, rs2_data);
   modport file (input  rs1_addr, rs2_addr, rd_we, rd_addr, rd_data,
                 output rs1_data, rs2_data);

endinterface

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int SHAMT_W    = $clog2(XLEN);
   localparam int OPC_W      = 7;
   localparam int INST_BYTES = 4;

   typedef logic [31:0] inst_t;

   // instruction field positions
   localparam int RD_LSB  = 7;
   localparam int F3_LSB  = 12;
   localparam int RS1_LSB = 15;
   localparam int RS2_LSB = 20;
   localparam int F7_LSB  = 25;

   localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
   localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
   localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
   localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
   localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
   localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
   localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;

   // branch conditions
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   // load and store widths
   localparam logic [2:0] F3_LB  = 3'b000;
   localparam logic [2:0] F3_LH  = 3'b001;
   localparam logic [2:0] F3_LW  = 3'b010;
   localparam logic [2:0] F3_LBU = 3'b100;
   localparam logic [2:0] F3_LHU = 3'b101;
   localparam logic [2:0] F3_SW  = 3'b010;

   localparam logic [2:0] F3_JALR = 3'b000;

   // alu ops, shared by OP and OP-IMM
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SR   = 3'b101;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

//--- verif/exec_unit_tb.sv
`timescale 1ns/1ns

module exec_unit_tb import rv_isa_pkg::*; ();

   localparam int K_NONE   = 0;
   localparam int K_STORE  = 1;
   localparam int K_BRANCH = 2;
   localparam int K_LOAD   = 3;
   localparam int K_INV    = 4;
   localparam int STEP_TIMEOUT = 20;
   localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                        3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
   localparam logic R_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                   1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
   localparam logic [2:0] BR_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

   logic        clk;
   logic        i_arst_n;
   logic [31:0] i_inst;
   logic [31:0] i_pc;
   logic        i_rd_valid;
   logic [31:0] i_rd_data;
   logic        i_wr_ready;
   logic [31:0] o_addr;
   logic        o_rd_ready;
   logic        o_wr_valid;
   logic [31:0] o_wr_data;
   logic [2:0]  o_wr_width;
   logic        o_pc_change;
   logic [31:0] o_new_pc;
   logic        o_finished;
   logic        o_invalid_inst;

   // step table
   logic [31:0] q_inst [$];
   logic [31:0] q_pc [$];
   int          q_kind [$];
   logic [31:0] q_a [$];
   logic [31:0] q_b [$];

   logic [31:0] ref_x [32];
   logic [31:0] mem [32];
   logic [31:0] lfsr_q;
   int          err_count;
   int          tests_run;
   int          tests_failed;

   tb_clock #(.PERIOD_NS(4)) u_clock (.o_clk(clk));

   exec_unit DUT (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_inst         (i_inst),
      .i_pc           (i_pc),
      .o_addr         (o_addr),
      .o_rd_ready     (o_rd_ready),
      .i_rd_valid     (i_rd_valid),
      .i_rd_data      (i_rd_data),
      .o_wr_valid     (o_wr_valid),
      .o_wr_data      (o_wr_data),
      .o_wr_width     (o_wr_width),
      .i_wr_ready     (i_wr_ready),
      .o_pc_change    (o_pc_change),
      .o_new_pc       (o_new_pc),
      .o_finished     (o_finished),
      .o_invalid_inst (o_invalid_inst)
   );

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   // memory fill depends on the full word address
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h0100_0193) ^ 32'h9E37_79B9 ^ {addr[15:0], ~addr[15:0]};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   // reference alu from the isa definitions
   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'b0, $signed(a) < $signed(b)};
         3'd3: return {31'b0, a < b};
         3'd4: return a ^ b;
         3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] addr);
      logic [31:0] lane;
      lane = mem[addr[6:2]] >> (8 * int'(addr[1:0]));
      case (f3)
         F3_LB:   return {{24{lane[7]}}, lane[7:0]};
         F3_LBU:  return {24'b0, lane[7:0]};
         F3_LH:   return {{16{lane[15]}}, lane[15:0]};
         F3_LHU:  return {16'b0, lane[15:0]};
         default: return lane;
      endcase
   endfunction

   task automatic add_step(input logic [31:0] inst, input logic [31:0] pc, input int kind,
                           input logic [31:0] a, input logic [31:0] b);
      q_inst.push_back(inst);
      q_pc.push_back(pc);
      q_kind.push_back(kind);
      q_a.push_back(a);
      q_b.push_back(b);
   endtask

   task automatic set_ref(input logic [4:0] rd, input logic [31:0] v);
      if (rd != 5'd0) begin
         ref_x[rd] = v;
      end
   endtask

   task automatic op_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
      logic alt;
      alt = (f3 == F3_SR) && imm[10];
      add_step(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), 32'h0, K_NONE, '0, '0);
      set_ref(rd, alu_ref(f3, alt, ref_x[rs1], sext12(imm)));
   endtask

   task automatic op_reg(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2);
      add_step(enc_r(R_ALT[op] ? F7_ALT : 7'd0, rs2, rs1, R_F3[op], rd), 32'h0, K_NONE,
               '0, '0);
      set_ref(rd, alu_ref(R_F3[op], R_ALT[op], ref_x[rs1], ref_x[rs2]));
   endtask

   // lui plus addi, upper part rounded when bit 11 is set
   task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] up;
      up = (v + 32'h800) >> 12;
      add_step({up[19:0], rd, OPC_LUI}, 32'h0, K_NONE, '0, '0);
      set_ref(rd, {up[19:0], 12'b0});
      op_imm(F3_ADD, rd, rd, v[11:0]);
   endtask

   task automatic store_check(input logic [4:0] rs2);
      add_step(enc_s(12'h100, rs2, 5'd0), 32'h0, K_STORE, ref_x[rs2], 32'h100);
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_step(input int s);
      case (q_kind[s])
         K_STORE: begin
            check_val("o_wr_valid", 32'(o_wr_valid), 32'h1);
            check_val("o_wr_data", o_wr_data, q_a[s]);
            check_val("o_addr", o_addr, q_b[s]);
            check_val("o_wr_width", 32'(o_wr_width), 32'h4);
         end
         K_BRANCH: begin
            check_val("o_pc_change", 32'(o_pc_change), q_a[s]);
            if (q_a[s][0]) begin
               check_val("o_new_pc", o_new_pc, q_b[s]);
            end
         end
         K_LOAD:  check_val("o_addr", o_addr, q_b[s]);
         K_INV:   check_val("o_invalid_inst", 32'(o_invalid_inst), q_a[s]);
         default: check_val("o_pc_change", 32'(o_pc_change), 32'h0);
      endcase
   endtask

   // applies the table one instruction at a time
   task automatic run_steps(input string name);
      int  errs_before;
      int  kind;
      int  k;
      int  d;
      logic done;
      errs_before = err_count;
      for (int s = 0; s < q_inst.size(); s++) begin
         kind   = q_kind[s];
         d      = int'(rand_bits(2));
         i_inst = q_inst[s];
         i_pc   = q_pc[s];
         k      = 0;
         done   = 1'b0;
         while (!done && k < STEP_TIMEOUT) begin
            i_rd_valid = (kind == K_LOAD) && (k == d);
            i_rd_data  = mem[q_b[s][6:2]];
            i_wr_ready = (kind != K_STORE) || (k >= d);
            #2;
            if (kind == K_LOAD && k == d) begin
               check_val("o_rd_ready", 32'(o_rd_ready), 32'h1);
            end
            if (o_finished || kind == K_INV) begin
               if ((kind == K_LOAD && k <= d) || (kind == K_STORE && k < d)) begin
                  $display("step %0d of %s finished before the memory answered", s, name);
                  err_count++;
               end
               check_step(s);
               done = 1'b1;
            end
            @(posedge clk);
            #1;
            k++;
         end
         if (!done) begin
            $display("step %0d of %s timed out waiting for o_finished", s, name);
            err_count++;
         end
      end
      q_inst.delete();
      q_pc.delete();
      q_kind.delete();
      q_a.delete();
      q_b.delete();
      tests_run++;
      if (err_count != errs_before) begin
         tests_failed++;
      end
      $display("test %s: %0d errors", name, err_count - errs_before);
   endtask

   initial begin
      logic [31:0] addr;
      logic [12:0] off;
      logic [11:0] ld_imm;
      logic [2:0]  ld_f3;
      lfsr_q       = 32'h8937_7754;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      i_arst_n     = 1'b0;
      i_inst       = 32'h0000_0013;
      i_pc         = '0;
      i_rd_valid   = 1'b0;
      i_rd_data    = '0;
      i_wr_ready   = 1'b0;
      for (int i = 0; i < 32; i++) begin
         ref_x[i] = '0;
         mem[i]   = fill_word(32'(i * 4));
      end
      repeat (16) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      #1;
      check_val("o_rd_ready", 32'(o_rd_ready), 32'h0);
      check_val("o_wr_valid", 32'(o_wr_valid), 32'h0);
      @(posedge clk);
      #1;

      add_step(32'h0000_007F, 32'h0, K_INV, 32'h1, '0);
      add_step(enc_i(12'h005, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM), 32'h0, K_INV, 32'h0, '0);
      run_steps("reset_invalid");

      // immediate forms and the 0x7ff/0x800 boundary
      load_const(5'd1, 32'h1234_5FFF);
      store_check(5'd1);
      load_const(5'd2, 32'h8000_0800);
      store_check(5'd2);
      op_imm(F3_ADD, 5'd3, 5'd1, 12'h7FF);
      store_check(5'd3);
      op_imm(F3_ADD, 5'd3, 5'd1, 12'h800);
      store_check(5'd3);
      op_imm(F3_SLT, 5'd4, 5'd2, 12'h800);
      store_check(5'd4);
      op_imm(F3_SLTU, 5'd4, 5'd1, 12'h800);
      store_check(5'd4);
      op_imm(F3_XOR, 5'd5, 5'd1, 12'h5A5);
      store_check(5'd5);
      op_imm(F3_OR, 5'd5, 5'd2, 12'h0F0);
      store_check(5'd5);
      op_imm(F3_AND, 5'd5, 5'd1, 12'h7F0);
      store_check(5'd5);
      op_imm(F3_SLL, 5'd6, 5'd1, 12'h007);
      store_check(5'd6);
      op_imm(F3_SR, 5'd6, 5'd2, 12'h00D);
      store_check(5'd6);
      op_imm(F3_SR, 5'd6, 5'd2, 12'h40D);
      store_check(5'd6);
      run_steps("alu_imm");

      for (int pass = 0; pass < 3; pass++) begin
         load_const(5'd10, pass == 2 ? 32'h8000_0000 : rand_bits(32));
         load_const(5'd11, pass == 2 ? 32'h7FFF_FFFF : rand_bits(32));
         for (int op = 0; op < 10; op++) begin
            op_reg(op, 5'd12, 5'd10, 5'd11);
            store_check(5'd12);
            op_reg(op, 5'd12, 5'd11, 5'd10);
            store_check(5'd12);
         end
      end
      run_steps("alu_reg");

      load_const(5'd10, 32'd5);
      load_const(5'd11, 32'hFFFF_FFFD);
      for (int b = 0; b < 6; b++) begin
         for (int p = 0; p < 3; p++) begin
            off  = {12'(rand_bits(12)), 1'b0};
            addr = 32'h0000_1000 + {{19{off[12]}}, off};
            add_step(enc_b(off, p == 0 ? 5'd11 : 5'd10, p == 1 ? 5'd11 : 5'd10, BR_F3[b]),
                     32'h0000_1000, K_BRANCH,
                     32'(branch_ref(BR_F3[b], ref_x[p == 1 ? 11 : 10],
                                    ref_x[p == 0 ? 11 : 10])), addr);
         end
      end
      run_steps("branch");

      add_step(enc_j(21'h0_0800, 5'd5), 32'h0000_2000, K_BRANCH, 32'h1, 32'h0000_2800);
      set_ref(5'd5, 32'h0000_2004);
      store_check(5'd5);
      add_step(enc_j(21'h1F_FFF0, 5'd5), 32'h0000_2000, K_BRANCH, 32'h1, 32'h0000_1FF0);
      add_step(enc_i(12'h011, 5'd10, F3_JALR, 5'd6, OPC_JALR), 32'h0000_2100, K_BRANCH,
               32'h1, (ref_x[10] + 32'h11) & ~32'h1);
      set_ref(5'd6, 32'h0000_2104);
      store_check(5'd6);
      add_step({20'h12345, 5'd7, OPC_AUIPC}, 32'h0000_3000, K_NONE, '0, '0);
      set_ref(5'd7, 32'h1234_8000);
      store_check(5'd7);
      run_steps("jump_auipc");

      load_const(5'd20, 32'h0000_0040);
      for (int f = 0; f < 5; f++) begin
         ld_f3 = (f == 0) ? F3_LB : (f == 1) ? F3_LBU : (f == 2) ? F3_LH :
                 (f == 3) ? F3_LHU : F3_LW;
         for (int o = 0; o < 4; o++) begin
            if (!((f >= 2 && o == 3) || (f == 4 && o != 0))) begin
               ld_imm = 12'({3'(rand_bits(3)), 2'(o)});
               addr   = ref_x[20] + sext12(ld_imm);
               add_step(enc_i(ld_imm, 5'd20, ld_f3, 5'd21, OPC_LOAD), 32'h0, K_LOAD,
                        '0, addr);
               set_ref(5'd21, load_ref(ld_f3, addr));
               store_check(5'd21);
            end
         end
      end
      run_steps("load");

      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
               err_count);
      if (err_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ns

// free-running testbench clock
module tb_clock #(
   parameter int PERIOD_NS = 4
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) o_clk = ~o_clk;
      end
   end

endmodule

//--- verilog.f
logic/rv_isa_pkg.sv
logic/exec_pkg.sv
logic/reg_port_if.sv
logic/exec_decoder.sv
logic/exec_regfile.sv
logic/exec_alu.sv
logic/exec_lsu.sv
logic/exec_commit.sv
logic/exec_unit.sv
verif/tb_clock.sv
verif/exec_unit_tb.sv
